//--- hdl/bpu.sv
`timescale 1ns/1ps

module bpu (
    input  logic           clk,
    input  logic           rst_n,

    input  bpu_pkg::addr_t f1_pc,           // f1
    output logic           f1_taken,
    output logic           pos,
    output bpu_pkg::addr_t pre_pc,

    input  logic           is_jr_ra_decode, // decode
    output logic           jr_ra_fail,

    input  bpu_pkg::addr_t exe_pc,          // exe
    input  bpu_pkg::addr_t dest_pc,
    input  bpu_pkg::addr_t ret_pc,
    input  logic           is_branch,
    input  logic           is_j,
    input  logic           is_jal,
    input  logic           is_jalr,
    input  logic           is_jr_ra_exe,
    input  logic           is_taken
);

    btb_update_if   upd_if [bpu_pkg::NUM_WAYS] ();
    btb_lookup_if   lk_if  [bpu_pkg::NUM_WAYS] ();
    bpu_pkg::addr_t ras_top;
    logic           ras_empty;
    logic           ras_pop;

    btb_alloc alloc_inst (
        .clk,
        .rst_n,
        .exe_pc,
        .dest_pc,
        .is_branch,
        .is_j,
        .is_jal,
        .is_jr_ra_exe,
        .is_taken,
        .upd          (upd_if)
    );

    for (genvar g = 0; g < bpu_pkg::NUM_WAYS; g++) begin : g_way
        btb_way way_inst (
            .clk,
            .rst_n,
            .f1_pc,
            .exe_pc,
            .upd    (upd_if[g]),
            .lk     (lk_if[g])
        );
    end

    pred_select sel_inst (
        .lk              (lk_if),
        .is_jr_ra_decode,
        .ras_top,
        .ras_empty,
        .pre_pc,
        .f1_taken,
        .pos,
        .ras_pop
    );

    ras ras_inst (
        .clk,
        .rst_n,
        .push        (is_jal | is_jalr),  // Calls push the link address
        .pop         (ras_pop),
        .ret_pc_push (ret_pc),
        .top         (ras_top),
        .empty       (ras_empty),
        .fail        (jr_ra_fail)
    );

endmodule

//--- hdl/bpu_pkg.sv
package bpu_pkg;

    localparam int NUM_WAYS     = 4;
    localparam int SET_BITS     = 4;
    localparam int NUM_SETS     = 1 << SET_BITS;
    localparam int TAG_BITS     = 32 - SET_BITS - 2;  // pc[31:6]
    localparam int COUNTER_BITS = 2;
    localparam int RAS_DEPTH    = 8;
    localparam int RAS_PTR_BITS = $clog2(RAS_DEPTH);

    typedef logic [31:0]               addr_t;
    typedef logic [$clog2(NUM_WAYS)-1:0] way_t;
    typedef logic [SET_BITS-1:0]       idx_t;
    typedef logic [TAG_BITS-1:0]       tag_t;
    typedef logic [COUNTER_BITS-1:0]   ctr_t;

    localparam ctr_t CTR_MAX  = '1;
    localparam ctr_t CTR_INIT = ctr_t'(1 << (COUNTER_BITS - 1));  // Weakly taken

    typedef enum logic [1:0] {
        KIND_BRANCH,
        KIND_JUMP,
        KIND_RETURN
    } entry_kind_e;

    typedef enum logic {
        SLOT_PC,
        SLOT_PCP4
    } slot_e;

    // Word-aligned set index
    function automatic idx_t pc_idx(addr_t pc);
        return pc[SET_BITS+1:2];
    endfunction

    function automatic tag_t pc_tag(addr_t pc);
        return pc[31:SET_BITS+2];
    endfunction

endpackage

//--- hdl/btb_alloc.sv
`timescale 1ns/1ps

module btb_alloc (
    input  logic           clk,
    input  logic           rst_n,
    input  bpu_pkg::addr_t exe_pc,
    input  bpu_pkg::addr_t dest_pc,
    input  logic           is_branch,
    input  logic           is_j,
    input  logic           is_jal,
    input  logic           is_jr_ra_exe,
    input  logic           is_taken,
    btb_update_if.alloc    upd [bpu_pkg::NUM_WAYS]
);

    logic [bpu_pkg::NUM_WAYS-1:0] hit_vec;
    logic [bpu_pkg::NUM_WAYS-1:0] valid_vec;
    bpu_pkg::ctr_t                exe_ctr [bpu_pkg::NUM_WAYS];
    bpu_pkg::entry_kind_e         kind;
    bpu_pkg::ctr_t                old_ctr;
    bpu_pkg::ctr_t                new_ctr;
    bpu_pkg::way_t                hit_way;
    bpu_pkg::way_t                free_way;
    bpu_pkg::way_t                victim;
    bpu_pkg::way_t                wr_way;
    logic                         any_hit;
    logic                         any_free;
    logic                         do_write;
    logic                         use_victim;
    logic                         target_we;

    always_comb begin
        kind = bpu_pkg::KIND_BRANCH;
        if (is_j || is_jal) begin
            kind = bpu_pkg::KIND_JUMP;
        end else if (is_jr_ra_exe) begin
            kind = bpu_pkg::KIND_RETURN;
        end
    end

    // Walk downward so the lowest way wins
    always_comb begin
        any_hit  = 1'b0;
        any_free = 1'b0;
        hit_way  = '0;
        free_way = '0;
        old_ctr  = '0;
        for (int w = bpu_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (hit_vec[w]) begin
                any_hit = 1'b1;
                hit_way = bpu_pkg::way_t'(w);
                old_ctr = exe_ctr[w];
            end
            if (!valid_vec[w]) begin
                any_free = 1'b1;
                free_way = bpu_pkg::way_t'(w);
            end
        end
    end

    always_comb begin
        if (!any_hit) begin
            new_ctr = bpu_pkg::CTR_INIT;
        end else if (is_taken) begin
            new_ctr = (old_ctr == bpu_pkg::CTR_MAX) ? old_ctr : old_ctr + 1'b1;
        end else begin
            new_ctr = (old_ctr == '0) ? old_ctr : old_ctr - 1'b1;
        end
    end

    // Not-taken branch misses allocate nothing
    assign do_write   = (is_branch && (any_hit || is_taken)) || is_j || is_jal || is_jr_ra_exe;
    assign target_we  = !is_branch || is_taken;
    assign wr_way     = any_hit ? hit_way : (any_free ? free_way : victim);
    assign use_victim = do_write && !any_hit && !any_free;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            victim <= '0;
        end else if (use_victim) begin
            victim <= victim + 1'b1;
        end
    end

    for (genvar g = 0; g < bpu_pkg::NUM_WAYS; g++) begin : g_port
        assign hit_vec[g]       = upd[g].exe_hit;
        assign valid_vec[g]     = upd[g].valid_at_idx;
        assign exe_ctr[g]       = upd[g].exe_counter;
        assign upd[g].we        = do_write && (wr_way == bpu_pkg::way_t'(g));
        assign upd[g].target_we = target_we;
        assign upd[g].idx       = bpu_pkg::pc_idx(exe_pc);
        assign upd[g].tag       = bpu_pkg::pc_tag(exe_pc);
        assign upd[g].target    = dest_pc;
        assign upd[g].kind      = kind;
        assign upd[g].counter   = new_ctr;
    end

endmodule

//--- hdl/btb_if.sv
`timescale 1ns/1ps

interface btb_update_if;
    logic                 we;
    logic                 target_we;    // Cleared on not-taken branch update
    bpu_pkg::idx_t        idx;
    bpu_pkg::tag_t        tag;
    bpu_pkg::addr_t       target;
    bpu_pkg::entry_kind_e kind;
    bpu_pkg::ctr_t        counter;
    logic                 exe_hit;
    bpu_pkg::ctr_t        exe_counter;
    logic                 valid_at_idx;

    modport alloc (
        output we, target_we, idx, tag, target, kind, counter,
        input  exe_hit, exe_counter, valid_at_idx
    );

    modport way (
        input  we, target_we, idx, tag, target, kind, counter,
        output exe_hit, exe_counter, valid_at_idx
    );
endinterface

interface btb_lookup_if;
    logic                 hit0;         // Slot at pc
    bpu_pkg::entry_kind_e kind0;
    bpu_pkg::addr_t       target0;
    bpu_pkg::ctr_t        ctr0;
    logic                 hit1;         // Slot at pc+4
    bpu_pkg::entry_kind_e kind1;
    bpu_pkg::addr_t       target1;
    bpu_pkg::ctr_t        ctr1;

    modport way (output hit0, kind0, target0, ctr0, hit1, kind1, target1, ctr1);
    modport sel (input  hit0, kind0, target0, ctr0, hit1, kind1, target1, ctr1);
endinterface

//--- hdl/btb_way.sv
`timescale 1ns/1ps

module btb_way (
    input  logic           clk,
    input  logic           rst_n,
    input  bpu_pkg::addr_t f1_pc,
    input  bpu_pkg::addr_t exe_pc,
    btb_update_if.way      upd,
    btb_lookup_if.way      lk
);

    logic [bpu_pkg::NUM_SETS-1:0] valid;
    bpu_pkg::tag_t                tag_mem    [bpu_pkg::NUM_SETS];
    bpu_pkg::addr_t               target_mem [bpu_pkg::NUM_SETS];
    bpu_pkg::entry_kind_e         kind_mem   [bpu_pkg::NUM_SETS];
    bpu_pkg::ctr_t                ctr_mem    [bpu_pkg::NUM_SETS];
    bpu_pkg::addr_t               pcp4;
    bpu_pkg::idx_t                idx0;
    bpu_pkg::idx_t                idx1;
    bpu_pkg::idx_t                exe_idx;

    assign pcp4    = f1_pc + 32'd4;
    assign idx0    = bpu_pkg::pc_idx(f1_pc);
    assign idx1    = bpu_pkg::pc_idx(pcp4);
    assign exe_idx = bpu_pkg::pc_idx(exe_pc);

    // Fetch read ports
    assign lk.hit0    = valid[idx0] && (tag_mem[idx0] == bpu_pkg::pc_tag(f1_pc));
    assign lk.kind0   = kind_mem[idx0];
    assign lk.target0 = target_mem[idx0];
    assign lk.ctr0    = ctr_mem[idx0];

    assign lk.hit1    = valid[idx1] && (tag_mem[idx1] == bpu_pkg::pc_tag(pcp4));  // May cross tag
    assign lk.kind1   = kind_mem[idx1];
    assign lk.target1 = target_mem[idx1];
    assign lk.ctr1    = ctr_mem[idx1];

    // Execute read port
    assign upd.exe_hit      = valid[exe_idx] && (tag_mem[exe_idx] == bpu_pkg::pc_tag(exe_pc));
    assign upd.exe_counter  = ctr_mem[exe_idx];
    assign upd.valid_at_idx = valid[exe_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (upd.we) begin
            valid[upd.idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (upd.we) begin
            tag_mem[upd.idx]  <= upd.tag;
            kind_mem[upd.idx] <= upd.kind;
            ctr_mem[upd.idx]  <= upd.counter;
            if (upd.target_we) begin
                target_mem[upd.idx] <= upd.target;
            end
        end
    end

endmodule

//--- hdl/pred_select.sv
`timescale 1ns/1ps

module pred_select (
    btb_lookup_if.sel      lk [bpu_pkg::NUM_WAYS],
    input  logic           is_jr_ra_decode,
    input  bpu_pkg::addr_t ras_top,
    input  logic           ras_empty,
    output bpu_pkg::addr_t pre_pc,
    output logic           f1_taken,
    output logic           pos,
    output logic           ras_pop
);

    logic [bpu_pkg::NUM_WAYS-1:0] hit_v    [2];
    bpu_pkg::entry_kind_e         kind_a   [2][bpu_pkg::NUM_WAYS];
    bpu_pkg::addr_t               target_a [2][bpu_pkg::NUM_WAYS];
    bpu_pkg::ctr_t                ctr_a    [2][bpu_pkg::NUM_WAYS];
    logic [1:0]                   slot_hit;
    logic [1:0]                   slot_taken;
    bpu_pkg::entry_kind_e         slot_kind   [2];
    bpu_pkg::addr_t               slot_target [2];
    bpu_pkg::ctr_t                slot_ctr    [2];
    bpu_pkg::slot_e               win;
    logic                         win_hit;
    logic                         win_ret;

    for (genvar g = 0; g < bpu_pkg::NUM_WAYS; g++) begin : g_gather
        assign hit_v[0][g]    = lk[g].hit0;
        assign kind_a[0][g]   = lk[g].kind0;
        assign target_a[0][g] = lk[g].target0;
        assign ctr_a[0][g]    = lk[g].ctr0;
        assign hit_v[1][g]    = lk[g].hit1;
        assign kind_a[1][g]   = lk[g].kind1;
        assign target_a[1][g] = lk[g].target1;
        assign ctr_a[1][g]    = lk[g].ctr1;
    end

    // At most one way hits per slot
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            slot_hit[s]    = |hit_v[s];
            slot_kind[s]   = bpu_pkg::KIND_BRANCH;
            slot_target[s] = '0;
            slot_ctr[s]    = '0;
            for (int w = 0; w < bpu_pkg::NUM_WAYS; w++) begin
                if (hit_v[s][w]) begin
                    slot_kind[s]   = kind_a[s][w];
                    slot_target[s] = target_a[s][w];
                    slot_ctr[s]    = ctr_a[s][w];
                end
            end
            slot_taken[s] = slot_hit[s] && (slot_kind[s] != bpu_pkg::KIND_BRANCH ||
                                            slot_ctr[s][bpu_pkg::COUNTER_BITS-1]);
        end
    end

    assign win     = slot_taken[0] ? bpu_pkg::SLOT_PC :
                     (slot_hit[1] ? bpu_pkg::SLOT_PCP4 : bpu_pkg::SLOT_PC);
    assign win_hit = slot_hit[win];
    assign win_ret = win_hit && (slot_kind[win] == bpu_pkg::KIND_RETURN);

    assign pos      = (win == bpu_pkg::SLOT_PC) && slot_hit[0];
    assign ras_pop  = is_jr_ra_decode || win_ret;
    assign f1_taken = win_ret ? !ras_empty : slot_taken[win];  // Empty stack kills return

    always_comb begin
        pre_pc = '0;
        if (is_jr_ra_decode || win_ret) begin
            pre_pc = ras_top;
        end else if (win_hit) begin
            pre_pc = slot_target[win];
        end
    end

endmodule

//--- hdl/ras.sv
`timescale 1ns/1ps

module ras (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           push,
    input  logic           pop,
    input  bpu_pkg::addr_t ret_pc_push,
    output bpu_pkg::addr_t top,
    output logic           empty,
    output logic           fail
);

    bpu_pkg::addr_t                  mem [bpu_pkg::RAS_DEPTH];
    logic [bpu_pkg::RAS_PTR_BITS-1:0] ptr;      // Next free slot
    logic [bpu_pkg::RAS_PTR_BITS-1:0] top_ptr;
    logic [bpu_pkg::RAS_PTR_BITS:0]   count;
    logic                             pop_ok;

    assign top_ptr = ptr - 1'b1;
    assign empty   = (count == '0);
    assign fail    = pop && empty;
    assign pop_ok  = pop && !empty;
    assign top     = empty ? '0 : mem[top_ptr];

    // When full, ptr already sits on the oldest entry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr   <= '0;
            count <= '0;
        end else if (push && !pop_ok) begin
            ptr <= ptr + 1'b1;
            if (count != (bpu_pkg::RAS_PTR_BITS + 1)'(bpu_pkg::RAS_DEPTH)) begin
                count <= count + 1'b1;
            end
        end else if (pop_ok && !push) begin
            ptr   <= top_ptr;
            count <= count - 1'b1;
        end
    end

    // Push with pop replaces the top
    always_ff @(posedge clk) begin
        if (push) begin
            mem[pop_ok ? top_ptr : ptr] <= ret_pc_push;
        end
    end

endmodule

//--- project.f
hdl/bpu_pkg.sv
hdl/btb_if.sv
hdl/btb_alloc.sv
hdl/btb_way.sv
hdl/pred_select.sv
hdl/ras.sv
hdl/bpu.sv
sim/bpu_checker.sv
sim/bpu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the BPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module bpu_tb -f project.f -o bpu_sim
./obj_dir/bpu_sim | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

//--- sim/bpu_checker.sv
`timescale 1ns/1ps

module bpu_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  int          test_num,           // 0 once all tests are done
    input  logic [31:0] f1_pc,
    input  logic        is_jr_ra_decode,
    input  logic [31:0] exe_pc,
    input  logic [31:0] dest_pc,
    input  logic [31:0] ret_pc,
    input  logic        is_branch,
    input  logic        is_j,
    input  logic        is_jal,
    input  logic        is_jalr,
    input  logic        is_jr_ra_exe,
    input  logic        is_taken,
    input  logic [31:0] pre_pc,
    input  logic        f1_taken,
    input  logic        pos,
    input  logic        jr_ra_fail,
    output int          total_errors
);

    typedef struct packed {
        logic [31:0] pre_pc;
        logic        taken;
        logic        pos;
        logic        fail;
        logic        pop;
    } pred_t;

    bit                   m_valid  [bpu_pkg::NUM_WAYS][16];
    logic [25:0]          m_tag    [bpu_pkg::NUM_WAYS][16];
    logic [31:0]          m_target [bpu_pkg::NUM_WAYS][16];
    bpu_pkg::entry_kind_e m_kind   [bpu_pkg::NUM_WAYS][16];
    int                   m_ctr    [bpu_pkg::NUM_WAYS][16];
    int                   victim;
    logic [31:0]          stack_q  [$];     // Back is the top
    int                   cur_test = 1;
    int                   test_checks = 0;
    int                   test_errors = 0;
    int                   all_checks = 0;
    int                   all_errors = 0;
    int                   tests_run = 0;
    int                   tests_failed = 0;

    assign total_errors = all_errors;

    function automatic string test_name(int n);
        case (n)
            1:       return "reset state";
            2:       return "branch training";
            3:       return "slot choice";
            4:       return "calls and returns";
            5:       return "victim replacement";
            default: return "random traffic";
        endcase
    endfunction

    function automatic int find_way(logic [31:0] pc);
        int found;
        found = -1;
        for (int w = bpu_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (m_valid[w][pc[5:2]] && m_tag[w][pc[5:2]] == pc[31:6]) begin
                found = w;
            end
        end
        return found;
    endfunction

    function automatic logic predicts_taken(int w, logic [31:0] pc);
        return m_kind[w][pc[5:2]] != bpu_pkg::KIND_BRANCH || m_ctr[w][pc[5:2]] >= 2;
    endfunction

    // Expected fetch outputs from the table and stack model
    function automatic pred_t predict(logic [31:0] pc, logic decode);
        pred_t       p;
        logic [31:0] win_pc;
        int          w0;
        int          w1;
        int          wi;
        logic        tk0;
        logic        pc_wins;
        logic        win_ret;
        w0      = find_way(pc);
        w1      = find_way(pc + 32'd4);
        tk0     = (w0 >= 0) && predicts_taken(w0, pc);
        pc_wins = tk0 || (w1 < 0);
        wi      = pc_wins ? w0 : w1;
        win_pc  = pc_wins ? pc : pc + 32'd4;
        win_ret = 1'b0;
        p.taken = 1'b0;
        if (wi >= 0) begin
            win_ret = (m_kind[wi][win_pc[5:2]] == bpu_pkg::KIND_RETURN);
            p.taken = predicts_taken(wi, win_pc);
        end
        p.pos  = pc_wins && (w0 >= 0);
        p.pop  = decode || win_ret;
        p.fail = p.pop && (stack_q.size() == 0);
        if (win_ret) begin
            p.taken = (stack_q.size() != 0);  // Nothing to return to
        end
        if (p.pop) begin
            p.pre_pc = (stack_q.size() != 0) ? stack_q[stack_q.size() - 1] : 32'd0;
        end else begin
            p.pre_pc = (wi >= 0) ? m_target[wi][win_pc[5:2]] : 32'd0;
        end
        return p;
    endfunction

    task automatic update_model(logic pop);
        int   idx;
        int   w;
        int   ctr;
        logic write;
        idx   = int'(exe_pc[5:2]);
        w     = find_way(exe_pc);
        write = (is_branch && (w >= 0 || is_taken)) || is_j || is_jal || is_jr_ra_exe;
        if (w >= 0) begin
            ctr = is_taken ? m_ctr[w][idx] + 1 : m_ctr[w][idx] - 1;
            ctr = (ctr > 3) ? 3 : ((ctr < 0) ? 0 : ctr);
        end else begin
            ctr = 2;
            for (int f = bpu_pkg::NUM_WAYS - 1; f >= 0; f--) begin
                if (!m_valid[f][idx]) begin
                    w = f;
                end
            end
            if (w < 0 && write) begin
                w      = victim;
                victim = (victim + 1) % bpu_pkg::NUM_WAYS;
            end
        end
        if (write) begin
            m_valid[w][idx] = 1'b1;
            m_tag[w][idx]   = exe_pc[31:6];
            m_ctr[w][idx]   = ctr;
            m_kind[w][idx]  = is_branch ? bpu_pkg::KIND_BRANCH :
                              (is_jr_ra_exe ? bpu_pkg::KIND_RETURN : bpu_pkg::KIND_JUMP);
            if (!is_branch || is_taken) begin
                m_target[w][idx] = dest_pc;
            end
        end
        if ((is_jal || is_jalr) && pop && stack_q.size() != 0) begin
            stack_q[stack_q.size() - 1] = ret_pc;
        end else if (is_jal || is_jalr) begin
            stack_q.push_back(ret_pc);
            if (stack_q.size() > bpu_pkg::RAS_DEPTH) begin
                void'(stack_q.pop_front());  // Oldest return lost
            end
        end else if (pop && stack_q.size() != 0) begin
            void'(stack_q.pop_back());
        end
    endtask

    always @(posedge clk) begin
        pred_t want;
        if (test_num != cur_test) begin
            $display("test %0d %s: %0d checks, %0d errors",
                     cur_test, test_name(cur_test), test_checks, test_errors);
            tests_run++;
            if (test_errors != 0) begin
                tests_failed++;
            end
            test_checks = 0;
            test_errors = 0;
            cur_test    = test_num;
            if (cur_test == 0) begin
                $display("tests %0d, failed %0d, checks %0d, errors %0d",
                         tests_run, tests_failed, all_checks, all_errors);
            end
        end
        if (!rst_n) begin
            m_valid = '{default: 1'b0};
            victim  = 0;
            stack_q.delete();
        end else if (cur_test != 0) begin
            want = predict(f1_pc, is_jr_ra_decode);
            test_checks++;
            all_checks++;
            if (pre_pc !== want.pre_pc || f1_taken !== want.taken || pos !== want.pos ||
                jr_ra_fail !== want.fail) begin
                $write("FAILED at %0t: f1_pc %h got pre_pc %h taken %b pos %b fail %b",
                       $time, f1_pc, pre_pc, f1_taken, pos, jr_ra_fail);
                $display(", expected pre_pc %h taken %b pos %b fail %b",
                         want.pre_pc, want.taken, want.pos, want.fail);
                test_errors++;
                all_errors++;
            end
            update_model(want.pop);
        end
    end

endmodule

//--- sim/bpu_tb.sv
`timescale 1ns/1ps

module bpu_tb;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 3;
    localparam int DIRECTED_CYCLES = 80;    // Tests 1 to 5 need about 55
    localparam int RANDOM_CYCLES   = 2000;
    localparam int WATCHDOG_NS     =
        2 * (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES) * CLK_PERIOD;
    localparam logic [31:0] IDLE_PC = 32'h0000_1000;  // Never trained

    typedef enum int {OP_NONE, OP_BRANCH, OP_J, OP_JAL, OP_JALR, OP_RET} op_e;

    logic        clk;
    logic        rst_n;
    logic [31:0] f1_pc;
    logic        f1_taken;
    logic        pos;
    logic [31:0] pre_pc;
    logic        is_jr_ra_decode;
    logic        jr_ra_fail;
    logic [31:0] exe_pc;
    logic [31:0] dest_pc;
    logic [31:0] ret_pc;
    logic        is_branch;
    logic        is_j;
    logic        is_jal;
    logic        is_jalr;
    logic        is_jr_ra_exe;
    logic        is_taken;
    int          test_num;
    int          next_test;
    int          total_errors;
    logic [31:0] lcg_state;

    bpu bpu_inst (.*);

    bpu_checker checker_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("FAIL: see errors above");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {8'h00, lcg_state[31:8]};
    endfunction

    // 8 tags over 4 sets, so sets overflow and evict
    function automatic logic [31:0] pool_addr(logic [31:0] r);
        return {23'd4096, r[2:0], 2'b00, r[4:3], 2'b00};
    endfunction

    task automatic drive(input logic [31:0] fpc, input logic decode, input op_e op,
                         input logic [31:0] pc, input logic [31:0] dest,
                         input logic [31:0] ret, input logic taken);
        @(negedge clk);
        test_num        = next_test;
        f1_pc           = fpc;
        is_jr_ra_decode = decode;
        exe_pc          = pc;
        dest_pc         = dest;
        ret_pc          = ret;
        is_taken        = taken;
        is_branch       = (op == OP_BRANCH);
        is_j            = (op == OP_J);
        is_jal          = (op == OP_JAL);
        is_jalr         = (op == OP_JALR);
        is_jr_ra_exe    = (op == OP_RET);
    endtask

    task automatic fetch(input logic [31:0] pc, input logic decode);
        drive(pc, decode, OP_NONE, 32'd0, 32'd0, 32'd0, 1'b0);
    endtask

    // Link address is pc+8, past the delay slot
    task automatic execute(input op_e op, input logic [31:0] pc, input logic [31:0] dest,
                           input logic taken);
        drive(IDLE_PC, 1'b0, op, pc, dest, pc + 32'd8, taken);
    endtask

    task automatic run_random();
        logic [31:0] r;
        logic [31:0] s;
        op_e         op;
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            r  = lcg_next();
            s  = lcg_next();
            op = (r[15:13] > 3'd5) ? OP_NONE : op_e'(int'(r[15:13]));
            drive(pool_addr(r), s[3:0] == 4'd0, op, pool_addr(s >> 5), pool_addr(r >> 5),
                  pool_addr(s >> 10), s[11]);
        end
    endtask

    initial begin
        lcg_state       = 32'd94;
        rst_n           = 1'b0;
        test_num        = 1;
        next_test       = 1;
        f1_pc           = IDLE_PC;
        is_jr_ra_decode = 1'b0;
        exe_pc          = 32'd0;
        dest_pc         = 32'd0;
        ret_pc          = 32'd0;
        is_branch       = 1'b0;
        is_j            = 1'b0;
        is_jal          = 1'b0;
        is_jalr         = 1'b0;
        is_jr_ra_exe    = 1'b0;
        is_taken        = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        fetch(32'h0040_0100, 1'b0);
        fetch(32'h0040_0100, 1'b1);             // Decode return on empty stack

        next_test = 2;
        execute(OP_BRANCH, 32'h0040_0100, 32'h0040_0800, 1'b1);
        fetch(32'h0040_0100, 1'b0);
        execute(OP_BRANCH, 32'h0040_0100, 32'h0040_0900, 1'b0);
        fetch(32'h0040_0100, 1'b0);
        execute(OP_BRANCH, 32'h0040_0100, 32'h0040_0900, 1'b0);
        fetch(32'h0040_0100, 1'b0);             // Not taken, old target kept
        execute(OP_BRANCH, 32'h0040_0200, 32'h0040_0900, 1'b0);
        fetch(32'h0040_0200, 1'b0);

        next_test = 3;
        execute(OP_J, 32'h0040_0304, 32'h0040_0a00, 1'b1);
        fetch(32'h0040_0300, 1'b0);
        execute(OP_BRANCH, 32'h0040_0400, 32'h0040_0b00, 1'b1);
        execute(OP_BRANCH, 32'h0040_0400, 32'h0040_0b00, 1'b0);
        execute(OP_J, 32'h0040_0404, 32'h0040_0c00, 1'b1);
        fetch(32'h0040_0400, 1'b0);

        next_test = 4;
        execute(OP_JAL, 32'h0040_0500, 32'h0040_2040, 1'b1);
        execute(OP_RET, 32'h0040_2040, 32'h0040_0508, 1'b1);
        fetch(32'h0040_2040, 1'b0);
        fetch(32'h0040_2040, 1'b0);             // Stack empty by now
        for (int i = 0; i < 10; i++) begin
            execute(OP_JAL, 32'h0050_0000 + 32'(i * 4), 32'h0060_0000, 1'b1);
        end
        repeat (9) fetch(IDLE_PC, 1'b1);

        next_test = 5;
        for (int k = 0; k < 6; k++) begin
            execute(OP_BRANCH, 32'h0040_0010 + 32'(k * 64), 32'h0040_3000, 1'b1);
        end
        for (int k = 0; k < 6; k++) begin
            fetch(32'h0040_0010 + 32'(k * 64), 1'b0);
        end

        next_test = 6;
        run_random();

        next_test = 0;
        fetch(IDLE_PC, 1'b0);
        @(negedge clk);
        if (total_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
